// ==== src.f ====
rv_isa_pkg.sv
core_pkg.sv
rv_decoder.sv
reg_file.sv
decode_stage.sv
exec_stage.sv
core_top.sv
tb_core.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_core
FILELIST  := src.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_core.sv ====
module tb_core import core_pkg::*, rv_isa_pkg::*; ();

  localparam logic [31:0] SEED        = 32'h77cf2d29;
  localparam int          N_RANDOM    = 300;
  localparam int          TOTAL_INSTS = 31 + N_RANDOM;
  localparam logic [1:0]  READY_HIGH  = 2'd0;
  localparam logic [1:0]  READY_LOW   = 2'd1;
  localparam logic [1:0]  READY_RAND  = 2'd2;

  logic     clk = 1'b0;
  logic     rst;
  logic     in_valid_i;
  inst_t    in_inst_i;
  xlen_t    in_pc_i;
  logic     in_ready_o;
  logic     wb_valid_o;
  reg_idx_t wb_rd_o;
  xlen_t    wb_data_o;
  logic     wb_wen_o;
  logic     wb_ready_i;

  logic [1:0]  ready_mode;
  logic [31:0] stim_state;
  logic [31:0] ready_state;
  xlen_t       pc;
  xlen_t       mregs [NUM_REGS];
  reg_idx_t    exp_rd_q [$];
  xlen_t       exp_data_q [$];
  logic        exp_wen_q [$];
  logic        head_valid;
  reg_idx_t    head_rd;
  xlen_t       head_data;
  logic        head_wen;
  int          accept_count = 0;
  int          commit_count = 0;
  string       test_name = "reset";

  core_top core_top_inst (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (in_valid_i),
    .in_inst_i  (in_inst_i),
    .in_pc_i    (in_pc_i),
    .in_ready_o (in_ready_o),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o),
    .wb_wen_o   (wb_wen_o),
    .wb_ready_i (wb_ready_i)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic inst_t enc_r(input logic [6:0] f7, input logic [3:0] rs2,
                                  input logic [3:0] rs1, input logic [2:0] f3,
                                  input logic [3:0] rd);
    return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, OP_REG};
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input logic [3:0] rs1,
                                  input logic [2:0] f3, input logic [3:0] rd);
    return {imm, 1'b0, rs1, f3, 1'b0, rd, OP_IMM};
  endfunction

  function automatic inst_t enc_u(input logic [19:0] imm, input logic [3:0] rd,
                                  input opcode_t opc);
    return {imm, 1'b0, rd, opc};
  endfunction

  // Upper LCG bits pick the fields. Bit 27 biases rs1 toward the last rd.
  function automatic inst_t random_inst(input logic [31:0] r, input logic [31:0] s,
                                        input logic [3:0] prev_rd);
    logic [3:0] rd;
    logic [3:0] rs1;
    logic [2:0] f3;
    logic [6:0] f7;
    rd  = r[31:28];
    rs1 = r[27] ? prev_rd : r[26:23];
    f3  = r[18:16];
    f7  = (r[15] && (f3 == F3_ADD || f3 == F3_SR)) ? F7_ALT : 7'b0;
    case (r[14:13])
      2'd0:    return enc_u(s[31:12], rd, OP_LUI);
      2'd1:    return enc_u(s[31:12], rd, OP_AUIPC);
      2'd2: begin
        if (f3 == F3_SLL || f3 == F3_SR) begin
          return enc_i({f7, s[24:20]}, rs1, f3, rd);
        end
        return enc_i(s[31:20], rs1, f3, rd);
      end
      default: return enc_r(f7, r[22:19], rs1, f3, rd);
    endcase
  endfunction

  function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input xlen_t a, input xlen_t b);
    xlen_t res;
    case (f3)
      F3_ADD:  res = alt ? a - b : a + b;
      F3_SLL:  res = a << b[4:0];
      F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
      F3_XOR:  res = a ^ b;
      F3_SR: begin
        if (alt) begin
          res = $signed(a) >>> b[4:0];
        end else begin
          res = a >> b[4:0];
        end
      end
      F3_OR:   res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    stop_on_error($sformatf("[FAIL] %s: %s expected %h, actual %h", test_name, what, exp, act));
  endtask

  // Executes an accepted instruction on the model registers.
  task automatic model_step(input inst_t inst, input xlen_t ipc);
    xlen_t    a;
    xlen_t    b;
    xlen_t    res;
    reg_idx_t rd;
    logic     wen;
    logic     alt;
    rd  = inst[10:7];
    a   = mregs[inst[18:15]];
    b   = mregs[inst[23:20]];
    alt = (inst[31:25] == F7_ALT);
    wen = 1'b1;
    case (inst[6:0])
      OP_LUI:   res = {inst[31:12], 12'b0};
      OP_AUIPC: res = ipc + {inst[31:12], 12'b0};
      OP_IMM:   res = alu_ref(inst[14:12], alt && (inst[14:12] == F3_SR), a,
                              {{20{inst[31]}}, inst[31:20]});
      OP_REG:   res = alu_ref(inst[14:12], alt, a, b);
      default: begin
        res = '0;
        wen = 1'b0;
      end
    endcase
    if (wen && rd != '0) begin
      mregs[rd] = res;
    end
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(res);
    exp_wen_q.push_back(wen);
  endtask

  always @(posedge clk) begin
    if (rst) begin
      exp_rd_q.delete();
      exp_data_q.delete();
      exp_wen_q.delete();
      for (int k = 0; k < NUM_REGS; k++) begin
        mregs[k] = '0;
      end
    end else begin
      if (wb_valid_o && wb_ready_i) begin
        if (exp_rd_q.size() != 0) begin
          void'(exp_rd_q.pop_front());
          void'(exp_data_q.pop_front());
          void'(exp_wen_q.pop_front());
        end
        commit_count++;
      end
      if (in_valid_i && in_ready_o) begin
        model_step(in_inst_i, in_pc_i);
        accept_count++;
      end
    end
    head_valid <= (exp_rd_q.size() != 0);
    head_rd    <= (exp_rd_q.size() != 0) ? exp_rd_q[0] : '0;
    head_data  <= (exp_rd_q.size() != 0) ? exp_data_q[0] : '0;
    head_wen   <= (exp_rd_q.size() != 0) ? exp_wen_q[0] : 1'b0;
  end

  always @(posedge clk) begin
    if (ready_mode == READY_RAND) begin
      ready_state = lcg_next(ready_state);
      wb_ready_i <= (ready_state[31:30] != 2'b00);  // About three in four.
    end else begin
      wb_ready_i <= (ready_mode == READY_HIGH);
    end
  end

  a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> (!wb_valid_o && in_ready_o))
    else stop_on_error("After reset the commit port was valid or the input was not ready.");

  a_commit_known: assert property (@(posedge clk) disable iff (rst)
      (wb_valid_o && wb_ready_i) |-> head_valid)
    else stop_on_error("A commit arrived with no instruction outstanding.");

  a_commit_rd: assert property (@(posedge clk) disable iff (rst)
      (wb_valid_o && wb_ready_i) |-> (wb_rd_o == head_rd))
    else fail_value("rd", 32'($sampled(head_rd)), 32'($sampled(wb_rd_o)));

  a_commit_wen: assert property (@(posedge clk) disable iff (rst)
      (wb_valid_o && wb_ready_i) |-> (wb_wen_o == head_wen))
    else fail_value("wen", 32'($sampled(head_wen)), 32'($sampled(wb_wen_o)));

  a_commit_data: assert property (@(posedge clk) disable iff (rst)
      (wb_valid_o && wb_ready_i && head_wen) |-> (wb_data_o == head_data))
    else fail_value("data", $sampled(head_data), $sampled(wb_data_o));

  // Holds valid until the input handshake takes the instruction.
  task automatic send(input inst_t inst);
    in_valid_i <= 1'b1;
    in_inst_i  <= inst;
    in_pc_i    <= pc;
    @(negedge clk);
    while (!in_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    in_valid_i <= 1'b0;
    pc = pc + 32'd4;
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (commit_count != accept_count) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  initial begin
    repeat (TOTAL_INSTS * 20) @(posedge clk);
    stop_on_error($sformatf("Timeout: commits stopped at %0d of %0d accepted instructions.",
                            commit_count, accept_count));
  end

  initial begin
    int          i;
    inst_t       inst;
    logic [31:0] r;
    logic [31:0] s;
    logic [3:0]  prev_rd;
    rst         <= 1'b1;
    in_valid_i  <= 1'b0;
    in_inst_i   <= '0;
    in_pc_i     <= '0;
    wb_ready_i  <= 1'b1;
    ready_mode  <= READY_HIGH;
    stim_state  = SEED;
    ready_state = lcg_next(SEED);
    pc          = 32'h0000_1000;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    test_name = "independent";  // Also gives x1 to x15 known values.
    for (i = 1; i < NUM_REGS; i++) begin
      case (i % 3)
        0:       send(enc_u(20'(i * 4951), 4'(i), OP_LUI));
        1:       send(enc_i(12'(i * 97), 4'd0, F3_ADD, 4'(i)));
        default: send(enc_u(20'(i), 4'(i), OP_AUIPC));
      endcase
    end
    wait_drain();

    test_name = "forward_chain";
    send(enc_i(12'h123, 4'd1, F3_ADD, 4'd1));
    send(enc_i({7'b0, 5'd4}, 4'd1, F3_SLL, 4'd2));
    send(enc_r(F7_ALT, 4'd1, 4'd2, F3_ADD, 4'd3));
    send(enc_i({F7_ALT, 5'd3}, 4'd3, F3_SR, 4'd4));
    send(enc_r(7'b0, 4'd3, 4'd4, F3_XOR, 4'd5));
    send(enc_r(7'b0, 4'd1, 4'd5, F3_SLTU, 4'd6));
    send(enc_r(F7_ALT, 4'd6, 4'd3, F3_SR, 4'd7));
    send(enc_r(7'b0, 4'd7, 4'd7, F3_AND, 4'd8));
    wait_drain();

    test_name = "commit_stall";
    ready_mode <= READY_LOW;
    @(posedge clk);
    send(enc_i(12'h155, 4'd0, F3_ADD, 4'd6));
    send(enc_u(20'habcde, 4'd9, OP_LUI));
    send(enc_r(7'b0, 4'd9, 4'd6, F3_ADD, 4'd10));  // x6 writer ends up in commit.
    inst = enc_i(12'h0f0, 4'd10, F3_XOR, 4'd11);
    in_valid_i <= 1'b1;
    in_inst_i  <= inst;
    in_pc_i    <= pc;
    repeat (6) @(negedge clk);
    assert (!in_ready_o)
      else stop_on_error("Input stayed ready while the commit port was stalled.");
    @(posedge clk);
    ready_mode <= READY_HIGH;
    send(inst);
    wait_drain();

    test_name = "x0_writes";
    send(enc_i(12'h055, 4'd1, F3_ADD, 4'd0));
    send(enc_r(7'b0, 4'd0, 4'd0, F3_ADD, 4'd9));
    send(enc_i(12'h03c, 4'd0, F3_OR, 4'd10));
    send(enc_r(F7_ALT, 4'd0, 4'd1, F3_ADD, 4'd11));
    wait_drain();

    test_name = "random";
    ready_mode <= READY_RAND;
    prev_rd = 4'd1;
    for (i = 0; i < N_RANDOM; i++) begin
      stim_state = lcg_next(stim_state);
      r = stim_state;
      stim_state = lcg_next(stim_state);
      s = stim_state;
      inst = random_inst(r, s, prev_rd);
      prev_rd = inst[10:7];
      send(inst);
    end
    ready_mode <= READY_HIGH;
    wait_drain();
    repeat (4) @(posedge clk);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== core_top.sv ====
module core_top import core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid_i,
  input  xlen_t    in_inst_i,
  input  xlen_t    in_pc_i,
  output logic     in_ready_o,
  output logic     wb_valid_o,
  output reg_idx_t wb_rd_o,
  output xlen_t    wb_data_o,
  output logic     wb_wen_o,
  input  logic     wb_ready_i
);

  reg_idx_t            raddr1;
  reg_idx_t            raddr2;
  xlen_t               rdata1;
  xlen_t               rdata2;
  logic [NUM_REGS-1:0] rf_busy;
  logic                fwd_valid;
  reg_idx_t            fwd_rd;
  xlen_t               fwd_data;
  logic                iss_valid;
  logic                iss_ready;
  alu_op_e             iss_op;
  xlen_t               iss_a;
  xlen_t               iss_b;
  reg_idx_t            iss_rd;
  logic                iss_wen;
  logic                set_busy;
  reg_idx_t            set_rd;
  logic                rf_we;

  decode_stage u_decode (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_inst_i   (in_inst_i),
    .in_pc_i     (in_pc_i),
    .in_ready_o  (in_ready_o),
    .raddr1_o    (raddr1),
    .raddr2_o    (raddr2),
    .rdata1_i    (rdata1),
    .rdata2_i    (rdata2),
    .busy_i      (rf_busy),
    .fwd_valid_i (fwd_valid),
    .fwd_rd_i    (fwd_rd),
    .fwd_data_i  (fwd_data),
    .iss_valid_o (iss_valid),
    .iss_ready_i (iss_ready),
    .iss_op_o    (iss_op),
    .iss_a_o     (iss_a),
    .iss_b_o     (iss_b),
    .iss_rd_o    (iss_rd),
    .iss_wen_o   (iss_wen),
    .set_busy_o  (set_busy),
    .set_rd_o    (set_rd)
  );

  reg_file u_rf (
    .clk        (clk),
    .rst        (rst),
    .raddr1_i   (raddr1),
    .raddr2_i   (raddr2),
    .we_i       (rf_we),
    .waddr_i    (wb_rd_o),  // Commit register drives the write port.
    .wdata_i    (wb_data_o),
    .set_busy_i (set_busy),
    .set_rd_i   (set_rd),
    .rdata1_o   (rdata1),
    .rdata2_o   (rdata2),
    .busy_o     (rf_busy)
  );

  exec_stage u_exec (
    .clk         (clk),
    .rst         (rst),
    .iss_valid_i (iss_valid),
    .iss_ready_o (iss_ready),
    .iss_op_i    (iss_op),
    .iss_a_i     (iss_a),
    .iss_b_i     (iss_b),
    .iss_rd_i    (iss_rd),
    .iss_wen_i   (iss_wen),
    .fwd_valid_o (fwd_valid),
    .fwd_rd_o    (fwd_rd),
    .fwd_data_o  (fwd_data),
    .wb_valid_o  (wb_valid_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o),
    .wb_wen_o    (wb_wen_o),
    .wb_ready_i  (wb_ready_i),
    .rf_we_o     (rf_we)
  );

endmodule

// ==== exec_stage.sv ====
module exec_stage import core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     iss_valid_i,
  output logic     iss_ready_o,
  input  alu_op_e  iss_op_i,
  input  xlen_t    iss_a_i,
  input  xlen_t    iss_b_i,
  input  reg_idx_t iss_rd_i,
  input  logic     iss_wen_i,
  output logic     fwd_valid_o,
  output reg_idx_t fwd_rd_o,
  output xlen_t    fwd_data_o,
  output logic     wb_valid_o,
  output reg_idx_t wb_rd_o,
  output xlen_t    wb_data_o,
  output logic     wb_wen_o,
  input  logic     wb_ready_i,
  output logic     rf_we_o
);

  logic     alu_valid_q;
  xlen_t    alu_res_q;
  reg_idx_t alu_rd_q;
  logic     alu_wen_q;
  xlen_t    alu_res;
  logic     cm_free;
  logic     move;

  always_comb begin
    case (iss_op_i)
      ADD:     alu_res = iss_a_i + iss_b_i;
      SUB:     alu_res = iss_a_i - iss_b_i;
      SLL:     alu_res = iss_a_i << iss_b_i[4:0];
      SLT:     alu_res = {31'b0, $signed(iss_a_i) < $signed(iss_b_i)};
      SLTU:    alu_res = {31'b0, iss_a_i < iss_b_i};
      XOR:     alu_res = iss_a_i ^ iss_b_i;
      SRL:     alu_res = iss_a_i >> iss_b_i[4:0];
      SRA:     alu_res = $signed(iss_a_i) >>> iss_b_i[4:0];
      OR:      alu_res = iss_a_i | iss_b_i;
      AND:     alu_res = iss_a_i & iss_b_i;
      PASS_B:  alu_res = iss_b_i;
      default: alu_res = '0;
    endcase
  end

  assign cm_free     = !wb_valid_o || wb_ready_i;
  assign move        = alu_valid_q && cm_free;
  assign iss_ready_o = !alu_valid_q || cm_free;

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_valid_q <= 1'b0;
      wb_valid_o  <= 1'b0;
    end else begin
      if (iss_valid_i && iss_ready_o) begin
        alu_valid_q <= 1'b1;
      end else if (move) begin
        alu_valid_q <= 1'b0;
      end
      if (move) begin
        wb_valid_o <= 1'b1;
      end else if (wb_ready_i) begin
        wb_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (iss_valid_i && iss_ready_o) begin
      alu_res_q <= alu_res;
      alu_rd_q  <= iss_rd_i;
      alu_wen_q <= iss_wen_i;
    end
    if (move) begin
      wb_data_o <= alu_res_q;
      wb_rd_o   <= alu_rd_q;
      wb_wen_o  <= alu_wen_q;
    end
  end

  // x0 never forwards.
  assign fwd_valid_o = alu_valid_q && alu_wen_q && (alu_rd_q != '0);
  assign fwd_rd_o    = alu_rd_q;
  assign fwd_data_o  = alu_res_q;

  assign rf_we_o = wb_valid_o && wb_ready_i && wb_wen_o;

endmodule

// ==== decode_stage.sv ====
module decode_stage import core_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  input  xlen_t               in_inst_i,
  input  xlen_t               in_pc_i,
  output logic                in_ready_o,
  output reg_idx_t            raddr1_o,
  output reg_idx_t            raddr2_o,
  input  xlen_t               rdata1_i,
  input  xlen_t               rdata2_i,
  input  logic [NUM_REGS-1:0] busy_i,
  input  logic                fwd_valid_i,
  input  reg_idx_t            fwd_rd_i,
  input  xlen_t               fwd_data_i,
  output logic                iss_valid_o,
  input  logic                iss_ready_i,
  output alu_op_e             iss_op_o,
  output xlen_t               iss_a_o,
  output xlen_t               iss_b_o,
  output reg_idx_t            iss_rd_o,
  output logic                iss_wen_o,
  output logic                set_busy_o,
  output reg_idx_t            set_rd_o
);

  logic  valid_q;
  xlen_t inst_q;
  xlen_t pc_q;
  logic  fwd1;
  logic  fwd2;
  xlen_t rs1v;
  xlen_t rs2v;
  logic  use_rs1;
  logic  use_rs2;
  logic  hazard;
  logic  issue;

  assign raddr1_o = inst_q[18:15];
  assign raddr2_o = inst_q[23:20];

  assign fwd1 = fwd_valid_i && (fwd_rd_i == raddr1_o);
  assign fwd2 = fwd_valid_i && (fwd_rd_i == raddr2_o);
  assign rs1v = fwd1 ? fwd_data_i : rdata1_i;
  assign rs2v = fwd2 ? fwd_data_i : rdata2_i;

  rv_decoder u_dec (
    .inst_i    (inst_q),
    .pc_i      (pc_q),
    .rs1v_i    (rs1v),
    .rs2v_i    (rs2v),
    .op_o      (iss_op_o),
    .a_o       (iss_a_o),
    .b_o       (iss_b_o),
    .rd_o      (iss_rd_o),
    .wen_o     (iss_wen_o),
    .use_rs1_o (use_rs1),
    .use_rs2_o (use_rs2)
  );

  // A busy rd also stalls, so a register has at most one writer in flight.
  assign hazard = (use_rs1 && busy_i[raddr1_o] && !fwd1) ||
                  (use_rs2 && busy_i[raddr2_o] && !fwd2) ||
                  (iss_wen_o && busy_i[iss_rd_o]);

  assign iss_valid_o = valid_q && !hazard;
  assign issue       = iss_valid_o && iss_ready_i;
  assign in_ready_o  = !valid_q || issue;

  assign set_busy_o = issue && iss_wen_o && (iss_rd_o != '0);
  assign set_rd_o   = iss_rd_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      valid_q <= 1'b1;
    end else if (issue) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      inst_q <= in_inst_i;
      pc_q   <= in_pc_i;
    end
  end

endmodule

// ==== reg_file.sv ====
module reg_file import core_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  reg_idx_t            raddr1_i,
  input  reg_idx_t            raddr2_i,
  input  logic                we_i,
  input  reg_idx_t            waddr_i,
  input  xlen_t               wdata_i,
  input  logic                set_busy_i,
  input  reg_idx_t            set_rd_i,
  output xlen_t               rdata1_o,
  output xlen_t               rdata2_o,
  output logic [NUM_REGS-1:0] busy_o
);

  xlen_t               regs [NUM_REGS];
  logic [NUM_REGS-1:0] busy_q;
  logic [NUM_REGS-1:0] busy_d;

  always_ff @(posedge clk) begin
    if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];  // x0 reads zero.
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

  always_comb begin
    busy_d = busy_q;
    if (we_i) begin
      busy_d[waddr_i] = 1'b0;
    end
    if (set_busy_i) begin
      busy_d[set_rd_i] = 1'b1;  // Set wins.
    end
    busy_d[0] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  assign busy_o = busy_q;

endmodule

// ==== rv_decoder.sv ====
module rv_decoder import core_pkg::*, rv_isa_pkg::*; (
  input  inst_t    inst_i,
  input  xlen_t    pc_i,
  input  xlen_t    rs1v_i,
  input  xlen_t    rs2v_i,
  output alu_op_e  op_o,
  output xlen_t    a_o,
  output xlen_t    b_o,
  output reg_idx_t rd_o,
  output logic     wen_o,
  output logic     use_rs1_o,
  output logic     use_rs2_o
);

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  xlen_t   imm_i;
  xlen_t   imm_u;
  logic    alt;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rd_o   = inst_i[10:7];  // Bit 11 unused in RV32E.
  assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u  = {inst_i[31:12], 12'b0};
  assign alt    = (funct7 == F7_ALT);

  function automatic alu_op_e alu_sel(input funct3_t f3, input logic sub_sra);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = sub_sra ? SUB : ADD;
      F3_SLL:  op = SLL;
      F3_SLT:  op = SLT;
      F3_SLTU: op = SLTU;
      F3_XOR:  op = XOR;
      F3_SR:   op = sub_sra ? SRA : SRL;
      F3_OR:   op = OR;
      F3_AND:  op = AND;
      default: op = ADD;
    endcase
    return op;
  endfunction

  always_comb begin
    op_o      = ADD;
    a_o       = rs1v_i;
    b_o       = rs2v_i;
    wen_o     = 1'b0;
    use_rs1_o = 1'b0;
    use_rs2_o = 1'b0;
    case (opcode)
      OP_LUI: begin
        op_o  = PASS_B;
        a_o   = '0;
        b_o   = imm_u;
        wen_o = 1'b1;
      end
      OP_AUIPC: begin
        a_o   = pc_i;
        b_o   = imm_u;
        wen_o = 1'b1;
      end
      OP_IMM: begin
        op_o      = alu_sel(funct3, alt && (funct3 == F3_SR));  // No SUBI.
        b_o       = imm_i;
        wen_o     = 1'b1;
        use_rs1_o = 1'b1;
      end
      OP_REG: begin
        op_o      = alu_sel(funct3, alt);
        wen_o     = 1'b1;
        use_rs1_o = 1'b1;
        use_rs2_o = 1'b1;
      end
      default: begin
        wen_o = 1'b0;  // Unsupported opcode passes without a write.
      end
    endcase
  end

endmodule

// ==== core_pkg.sv ====
package core_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [3:0]  reg_idx_t;

  localparam int NUM_REGS = 16;  // RV32E register count.

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B  // LUI result.
  } alu_op_e;

endpackage

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  localparam opcode_t OP_LUI   = 7'b0110111;
  localparam opcode_t OP_AUIPC = 7'b0010111;
  localparam opcode_t OP_IMM   = 7'b0010011;
  localparam opcode_t OP_REG   = 7'b0110011;

  localparam funct3_t F3_ADD  = 3'b000;  // ADD, SUB and ADDI.
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;  // SRL and SRA share it.
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  localparam funct7_t F7_ALT = 7'b0100000;  // Selects SUB and SRA.

endpackage
